// File: design/field_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// field slot limit, default field widths and
// the packed word width function
// ~~~~~~~~~~~~~~~~~~~~

package field_pkg;

    // data, user, first, last
    parameter int FIELD_MAX = 4;

    // any of these may be zero
    parameter int DATA_W_DEF  = 8;
    parameter int USER_W_DEF  = 0;
    parameter int FIRST_W_DEF = 1;
    parameter int LAST_W_DEF  = 1;

    // total packed width over all lanes, never below one bit
    function automatic int pack_width(
        input int n,
        input int w0,
        input int w1,
        input int w2,
        input int w3
    );
        int total;
        total = n * (w0 + w1 + w2 + w3);
        return (total > 0) ? total : 1;
    endfunction

endpackage

// File: design/fifo_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// FIFO status struct and default depth
// ~~~~~~~~~~~~~~~~~~~~

package fifo_pkg;

    parameter int DEPTH_DEF = 8;

    // wide enough for the default depth plus one
    parameter int STATUS_COUNT_W = 4;

    typedef struct packed {
        logic                      full;
        logic                      empty;
        logic [STATUS_COUNT_W-1:0] count;
    } fifo_status_t;

endpackage

// File: design/field_pack.sv
// ~~~~~~~~~~~~~~~~~~~~
// field packer: joins up to four fields per lane
// into one word, zero widths allowed
// ~~~~~~~~~~~~~~~~~~~~

module field_pack
    import field_pkg::*;
#(
    parameter int N  = 2,
    parameter int W0 = DATA_W_DEF,
    parameter int W1 = USER_W_DEF,
    parameter int W2 = FIRST_W_DEF,
    parameter int W3 = LAST_W_DEF,

    localparam int IN0_BITS = (N * W0 > 0) ? N * W0 : 1,
    localparam int IN1_BITS = (N * W1 > 0) ? N * W1 : 1,
    localparam int IN2_BITS = (N * W2 > 0) ? N * W2 : 1,
    localparam int IN3_BITS = (N * W3 > 0) ? N * W3 : 1,
    localparam int OUT_BITS = pack_width(N, W0, W1, W2, W3)
) (
    input  logic [IN0_BITS-1:0] in0,
    input  logic [IN1_BITS-1:0] in1,
    input  logic [IN2_BITS-1:0] in2,
    input  logic [IN3_BITS-1:0] in3,
    output logic [OUT_BITS-1:0] out
);

    localparam int LANE_W    = W0 + W1 + W2 + W3;
    localparam int LANE_BITS = (LANE_W > 0) ? LANE_W : 1;

    localparam int WF  [FIELD_MAX] = '{W0, W1, W2, W3};
    localparam int OFF [FIELD_MAX] = '{0, W0, W0 + W1, W0 + W1 + W2};

    // per-lane stride in each port, one bit for an empty field
    localparam int IND0 = (W0 > 0) ? W0 : 1;
    localparam int IND1 = (W1 > 0) ? W1 : 1;
    localparam int IND2 = (W2 > 0) ? W2 : 1;
    localparam int IND3 = (W3 > 0) ? W3 : 1;

    logic [N*IND0-1:0]      in0_d;
    logic [N*IND1-1:0]      in1_d;
    logic [N*IND2-1:0]      in2_d;
    logic [N*IND3-1:0]      in3_d;
    logic [N*LANE_BITS-1:0] lanes;

    // mask to width, then move up to the field's offset
    function automatic logic [LANE_BITS-1:0] place(
        input logic [LANE_BITS-1:0] v,
        input int                   w,
        input int                   off
    );
        logic [LANE_BITS:0] mask;
        mask = ((LANE_BITS + 1)'(1) << w) - 1'b1;
        return (v & mask[LANE_BITS-1:0]) << off;
    endfunction

    // stretch the one-bit stand-in ports to a full lane stride
    assign in0_d = (N * IND0)'(in0);
    assign in1_d = (N * IND1)'(in1);
    assign in2_d = (N * IND2)'(in2);
    assign in3_d = (N * IND3)'(in3);

    always_comb begin
        for (int i = 0; i < N; i++) begin
            lanes[i*LANE_BITS +: LANE_BITS] =
                  place(LANE_BITS'(in0_d[i*IND0 +: IND0]), WF[0], OFF[0])
                | place(LANE_BITS'(in1_d[i*IND1 +: IND1]), WF[1], OFF[1])
                | place(LANE_BITS'(in2_d[i*IND2 +: IND2]), WF[2], OFF[2])
                | place(LANE_BITS'(in3_d[i*IND3 +: IND3]), WF[3], OFF[3]);
        end
    end

    // all-zero layout leaves a single zero bit
    assign out = OUT_BITS'(lanes);

endmodule

// File: design/field_unpack.sv
// ~~~~~~~~~~~~~~~~~~~~
// field unpacker: splits a packed word back into
// per-lane fields, zero for empty fields
// ~~~~~~~~~~~~~~~~~~~~

module field_unpack
    import field_pkg::*;
#(
    parameter int N  = 2,
    parameter int W0 = DATA_W_DEF,
    parameter int W1 = USER_W_DEF,
    parameter int W2 = FIRST_W_DEF,
    parameter int W3 = LAST_W_DEF,

    localparam int OUT0_BITS = (N * W0 > 0) ? N * W0 : 1,
    localparam int OUT1_BITS = (N * W1 > 0) ? N * W1 : 1,
    localparam int OUT2_BITS = (N * W2 > 0) ? N * W2 : 1,
    localparam int OUT3_BITS = (N * W3 > 0) ? N * W3 : 1,
    localparam int IN_BITS   = pack_width(N, W0, W1, W2, W3)
) (
    input  logic [IN_BITS-1:0]   in,
    output logic [OUT0_BITS-1:0] out0,
    output logic [OUT1_BITS-1:0] out1,
    output logic [OUT2_BITS-1:0] out2,
    output logic [OUT3_BITS-1:0] out3
);

    localparam int LANE_W    = W0 + W1 + W2 + W3;
    localparam int LANE_BITS = (LANE_W > 0) ? LANE_W : 1;

    // same offsets as field_pack
    localparam int WF  [FIELD_MAX] = '{W0, W1, W2, W3};
    localparam int OFF [FIELD_MAX] = '{0, W0, W0 + W1, W0 + W1 + W2};

    localparam int IND0 = (W0 > 0) ? W0 : 1;
    localparam int IND1 = (W1 > 0) ? W1 : 1;
    localparam int IND2 = (W2 > 0) ? W2 : 1;
    localparam int IND3 = (W3 > 0) ? W3 : 1;

    logic [N*LANE_BITS-1:0] in_d;
    logic [N*IND0-1:0]      out0_d;
    logic [N*IND1-1:0]      out1_d;
    logic [N*IND2-1:0]      out2_d;
    logic [N*IND3-1:0]      out3_d;

    // a zero width gives an all-zero mask
    function automatic logic [LANE_BITS-1:0] take(
        input logic [LANE_BITS-1:0] lane,
        input int                   w,
        input int                   off
    );
        logic [LANE_BITS:0] mask;
        mask = ((LANE_BITS + 1)'(1) << w) - 1'b1;
        return (lane >> off) & mask[LANE_BITS-1:0];
    endfunction

    assign in_d = (N * LANE_BITS)'(in);

    always_comb begin
        for (int i = 0; i < N; i++) begin
            out0_d[i*IND0 +: IND0] = IND0'(take(in_d[i*LANE_BITS +: LANE_BITS], WF[0], OFF[0]));
            out1_d[i*IND1 +: IND1] = IND1'(take(in_d[i*LANE_BITS +: LANE_BITS], WF[1], OFF[1]));
            out2_d[i*IND2 +: IND2] = IND2'(take(in_d[i*LANE_BITS +: LANE_BITS], WF[2], OFF[2]));
            out3_d[i*IND3 +: IND3] = IND3'(take(in_d[i*LANE_BITS +: LANE_BITS], WF[3], OFF[3]));
        end
    end

    assign out0 = OUT0_BITS'(out0_d);
    assign out1 = OUT1_BITS'(out1_d);
    assign out2 = OUT2_BITS'(out2_d);
    assign out3 = OUT3_BITS'(out3_d);

endmodule

// File: design/sync_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~
// synchronous FIFO with registered read,
// occupancy count and full/empty status
// ~~~~~~~~~~~~~~~~~~~~

module sync_fifo
    import fifo_pkg::*;
#(
    parameter int WIDTH = 8,
    parameter int DEPTH = DEPTH_DEF
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] wr_word,
    input  logic             rd_en,
    output logic [WIDTH-1:0] rd_word,
    output logic             rd_valid,
    output fifo_status_t     status
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    // wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_wr = wr_en && !status.full;
    assign do_rd = rd_en && !status.empty;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // read and write together leave the count alone
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_word;
        end
    end

    // oldest word appears one cycle after the pop
    always_ff @(posedge clk) begin
        if (do_rd) begin
            rd_word <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= do_rd;
        end
    end

    assign status.full  = (count == CNT_W'(DEPTH));
    assign status.empty = (count == '0);
    assign status.count = STATUS_COUNT_W'(count);

    // writer has no back-pressure and must watch full
    a_no_write_full: assert property (
        @(posedge clk) disable iff (!arst_n) wr_en |-> !status.full
    ) else $error("write strobe while FIFO full");

    a_no_read_empty: assert property (
        @(posedge clk) disable iff (!arst_n) rd_en |-> !status.empty
    ) else $error("read strobe while FIFO empty");

    // pointers meet only when empty or full
    a_count_bound: assert property (
        @(posedge clk) disable iff (!arst_n)
            (count <= CNT_W'(DEPTH))
            && ((wr_ptr == rd_ptr) == (status.empty || status.full))
    ) else $error("occupancy above depth or out of step with the pointers");

endmodule

// File: design/field_stream_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~
// field stream FIFO top: pack, store, unpack
// ~~~~~~~~~~~~~~~~~~~~

module field_stream_fifo
    import field_pkg::*;
    import fifo_pkg::*;
#(
    parameter int N       = 2,
    parameter int DATA_W  = DATA_W_DEF,
    parameter int USER_W  = USER_W_DEF,
    parameter int FIRST_W = FIRST_W_DEF,
    parameter int LAST_W  = LAST_W_DEF,
    parameter int DEPTH   = DEPTH_DEF,

    localparam int DATA_BITS  = (N * DATA_W > 0) ? N * DATA_W : 1,
    localparam int USER_BITS  = (N * USER_W > 0) ? N * USER_W : 1,
    localparam int FIRST_BITS = (N * FIRST_W > 0) ? N * FIRST_W : 1,
    localparam int LAST_BITS  = (N * LAST_W > 0) ? N * LAST_W : 1
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  wr_en,
    input  logic [DATA_BITS-1:0]  data_in,
    input  logic [USER_BITS-1:0]  user_in,
    input  logic [FIRST_BITS-1:0] first_in,
    input  logic [LAST_BITS-1:0]  last_in,
    input  logic                  rd_en,
    output logic [DATA_BITS-1:0]  data_out,
    output logic [USER_BITS-1:0]  user_out,
    output logic [FIRST_BITS-1:0] first_out,
    output logic [LAST_BITS-1:0]  last_out,
    output logic                  rd_valid,
    output fifo_status_t          status
);

    localparam int WORD_W = pack_width(N, DATA_W, USER_W, FIRST_W, LAST_W);

    logic [WORD_W-1:0] wr_word;
    logic [WORD_W-1:0] rd_word;

    // slot order: data, user, first, last
    field_pack #(
        .N  (N),
        .W0 (DATA_W),
        .W1 (USER_W),
        .W2 (FIRST_W),
        .W3 (LAST_W)
    ) field_pack_inst (
        .in0 (data_in),
        .in1 (user_in),
        .in2 (first_in),
        .in3 (last_in),
        .out (wr_word)
    );

    sync_fifo #(
        .WIDTH (WORD_W),
        .DEPTH (DEPTH)
    ) sync_fifo_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr_en    (wr_en),
        .wr_word  (wr_word),
        .rd_en    (rd_en),
        .rd_word  (rd_word),
        .rd_valid (rd_valid),
        .status   (status)
    );

    field_unpack #(
        .N  (N),
        .W0 (DATA_W),
        .W1 (USER_W),
        .W2 (FIRST_W),
        .W3 (LAST_W)
    ) field_unpack_inst (
        .in   (rd_word),
        .out0 (data_out),
        .out1 (user_out),
        .out2 (first_out),
        .out3 (last_out)
    );

endmodule

// File: test/tb_field_stream_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~
// testbench for the field stream FIFO: trace reader,
// FIFO reference queue, checks and watchdog
// ~~~~~~~~~~~~~~~~~~~~

module tb_field_stream_fifo
    import fifo_pkg::*;
;

    localparam int    N          = 2;
    localparam int    DATA_W     = 8;
    localparam int    USER_W     = 0;
    localparam int    FIRST_W    = 1;
    localparam int    LAST_W     = 1;
    localparam int    DEPTH      = DEPTH_DEF;
    localparam int    CLK_PERIOD = 4;
    localparam string TRACE_FILE = "test/field_fifo_trace.txt";

    typedef struct packed {
        logic [7:0]  op;
        logic [15:0] data;
        logic [0:0]  user;
        logic [1:0]  first;
        logic [1:0]  last;
        logic [3:0]  count;
    } trace_op_t;

    typedef struct packed {
        logic [15:0] data;
        logic [1:0]  first;
        logic [1:0]  last;
    } beat_t;

    logic         clk;
    logic         arst_n;
    logic         wr_en;
    logic [15:0]  data_in;
    logic [0:0]   user_in;
    logic [1:0]   first_in;
    logic [1:0]   last_in;
    logic         rd_en;
    logic [15:0]  data_out;
    logic [0:0]   user_out;
    logic [1:0]   first_out;
    logic [1:0]   last_out;
    logic         rd_valid;
    fifo_status_t status;

    trace_op_t   trace_q[$];
    beat_t       model_q[$];
    beat_t       cur_beat;
    logic [31:0] lcg_state = 32'h8251;
    bit          trace_loaded = 1'b0;
    int          value_errors = 0;
    int          other_errors = 0;

    field_stream_fifo #(
        .N       (N),
        .DATA_W  (DATA_W),
        .USER_W  (USER_W),
        .FIRST_W (FIRST_W),
        .LAST_W  (LAST_W),
        .DEPTH   (DEPTH)
    ) field_stream_fifo_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .wr_en     (wr_en),
        .data_in   (data_in),
        .user_in   (user_in),
        .first_in  (first_in),
        .last_in   (last_in),
        .rd_en     (rd_en),
        .data_out  (data_out),
        .user_out  (user_out),
        .first_out (first_out),
        .last_out  (last_out),
        .rd_valid  (rd_valid),
        .status    (status)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            value_errors++;
            $display("** Error: %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic load_trace(output bit ok);
        int        fd;
        int        n;
        string     line;
        byte       op;
        int        d, u, f, l, c;
        trace_op_t t;
        ok = 1'b0;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            other_errors++;
            $display("trace file %s could not be opened", TRACE_FILE);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                // comments and blank lines
                if (n > 0 && line[0] != "#" && line[0] != "\n") begin
                    n = $sscanf(line, "%c %h %h %h %h %h", op, d, u, f, l, c);
                    if (n != 6 || !(op inside {"w", "r", "b", "i", "x"})) begin
                        other_errors++;
                        $display("trace line could not be parsed: %s", line);
                    end else begin
                        t = '{op: op, data: d, user: u, first: f, last: l, count: c};
                        trace_q.push_back(t);
                    end
                end
            end
            $fclose(fd);
            ok = 1'b1;
        end
    endtask

    // x lines take their fields from the LCG
    task automatic drive_line(input trace_op_t t);
        if (t.op == "x") begin
            lcg_state = lcg_next(lcg_state);
            cur_beat.data  = lcg_state[31:16];
            cur_beat.first = lcg_state[9:8];
            cur_beat.last  = lcg_state[5:4];
            user_in        = lcg_state[12];
        end else begin
            cur_beat.data  = t.data;
            cur_beat.first = t.first;
            cur_beat.last  = t.last;
            user_in        = t.user;
        end
        data_in  = cur_beat.data;
        first_in = cur_beat.first;
        last_in  = cur_beat.last;
        wr_en    = t.op inside {"w", "b", "x"};
        rd_en    = t.op inside {"r", "b"};
    endtask

    task automatic check_line(input trace_op_t t);
        beat_t exp;
        bit    rd;
        bit    wr;
        rd = t.op inside {"r", "b"};
        wr = t.op inside {"w", "b", "x"};
        check_value("status.count", status.count, t.count);
        if (rd) begin
            if (model_q.size() == 0) begin
                other_errors++;
                $display("trace reads while the reference queue is empty at %0t", $time);
            end else begin
                exp = model_q.pop_front();
                check_value("data_out", data_out, exp.data);
                check_value("first_out", first_out, exp.first);
                check_value("last_out", last_out, exp.last);
                // user field has zero width
                check_value("user_out", user_out, 0);
            end
        end
        if (wr) begin
            model_q.push_back(cur_beat);
        end
        check_value("status.full", status.full, model_q.size() == DEPTH);
        check_value("status.empty", status.empty, model_q.size() == 0);
        check_value("rd_valid", rd_valid, rd);
    endtask

    task automatic finish_run();
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    initial begin
        bit ok;
        clk      = 1'b0;
        arst_n   = 1'b0;
        wr_en    = 1'b0;
        rd_en    = 1'b0;
        data_in  = '0;
        user_in  = '0;
        first_in = '0;
        last_in  = '0;
        load_trace(ok);
        if (!ok) begin
            finish_run();
        end else begin
            trace_loaded = 1'b1;
            repeat (3) @(posedge clk);
            #1;
            arst_n = 1'b1;
            check_value("status.empty", status.empty, 1);
            check_value("status.full", status.full, 0);
            check_value("status.count", status.count, 0);
            check_value("rd_valid", rd_valid, 0);
            // each line is sampled at the next edge and checked just after it
            foreach (trace_q[i]) begin
                drive_line(trace_q[i]);
                @(posedge clk);
                #1;
                check_line(trace_q[i]);
            end
            wr_en = 1'b0;
            rd_en = 1'b0;
            @(posedge clk);
            #1;
            finish_run();
        end
    end

    initial begin
        int limit;
        wait (trace_loaded);
        limit = (trace_q.size() + 20) * CLK_PERIOD;
        #(limit);
        other_errors++;
        $display("watchdog expired after %0d time units, the run did not finish", limit);
        finish_run();
    end

endmodule

// File: filelist.f
design/field_pkg.sv
design/fifo_pkg.sv
design/field_pack.sv
design/field_unpack.sv
design/sync_fifo.sv
design/field_stream_fifo.sv
test/tb_field_stream_fifo.sv

// File: Bender.yml
package:
  name: field_stream_fifo

sources:
  - design/field_pkg.sv
  - design/fifo_pkg.sv
  - design/field_pack.sv
  - design/field_unpack.sv
  - design/sync_fifo.sv
  - design/field_stream_fifo.sv
  - target: test
    files:
      - test/tb_field_stream_fifo.sv

// File: test/field_fifo_trace.txt
# op: w write, r read, b read and write, i idle, x write with generated fields
# columns: op data user first last count, all hex; count is expected after the edge
i 0000 0 0 0 0
w a512 1 1 0 1
w 3c7e 0 0 2 2
i 0000 0 0 0 2
r 0000 0 0 0 1
r 0000 0 0 0 0
i 0000 0 0 0 0
w 0101 1 3 0 1
x 0000 0 0 0 2
w 0202 0 0 3 3
x 0000 0 0 0 4
w f00f 1 2 1 5
x 0000 0 0 0 6
w 7e81 0 1 2 7
x 0000 0 0 0 8
i 0000 0 0 0 8
r 0000 0 0 0 7
b 1111 1 3 3 7
b 2222 0 0 1 7
x 0000 0 0 0 8
r 0000 0 0 0 7
r 0000 0 0 0 6
r 0000 0 0 0 5
r 0000 0 0 0 4
b 3333 0 2 0 4
r 0000 0 0 0 3
r 0000 0 0 0 2
i 0000 0 0 0 2
r 0000 0 0 0 1
r 0000 0 0 0 0
i 0000 0 0 0 0
w beef 1 1 1 1
b cafe 0 2 2 1
b 5a5a 1 3 0 1
r 0000 0 0 0 0
i 0000 0 0 0 0
x 0000 0 0 0 1
r 0000 0 0 0 0
